/* design/sdr_board_defines.svh */
// Board control constants for the SDR bring-up slice
// Hold-off length, codec SPI timing and APB register map

`ifndef SDR_BOARD_DEFINES_SVH
`define SDR_BOARD_DEFINES_SVH

////////////////////////////////////////
// Clock bring-up
////////////////////////////////////////

// Hold-off counter width, ready after 2**N cycles of lock
`define SDR_HOLDOFF_BITS 8

////////////////////////////////////////
// Codec SPI
////////////////////////////////////////

`define SDR_SPI_HALF 2     // bus_clk cycles per half SCLK period
`define SDR_SPI_BITS 24    // Transceiver frame length

////////////////////////////////////////
// APB register map, byte offsets
////////////////////////////////////////

`define SDR_REG_MISC     8'h00   // Ref select, codec run, PPS source
`define SDR_REG_FE_GPIO  8'h04   // RF switches, PA enable, LEDs
`define SDR_REG_SPI_DATA 8'h08   // Write starts a frame, read gives reply
`define SDR_REG_STATUS   8'h0C   // Read only

`endif

/* design/sdr_board_pkg.sv */
// Shared types for the SDR board control slice
// Bus words, control bytes and the SPI state encoding

`include "sdr_board_defines.svh"

package sdr_board_pkg;

   ////////////////////////////////////////
   // APB settings bus
   ////////////////////////////////////////

   typedef logic [7:0]  apb_addr_t;   // Byte address
   typedef logic [31:0] apb_data_t;

   ////////////////////////////////////////
   // Control words
   ////////////////////////////////////////

   typedef logic [`SDR_SPI_BITS-1:0] spi_word_t;   // One codec frame

   // Bits 7..3 switches and PA, bits 2..0 LEDs
   typedef logic [7:0] fe_gpio_t;

   // Bit0 ref_sel, bit1 codec_run, bit2 ext_ref_is_pps
   typedef logic [2:0] misc_t;

   // Codec SPI master FSM
   typedef enum logic [1:0] {
      SPI_IDLE,    // Enable high, waiting for a start
      SPI_LEAD,    // Enable low, first bit set up
      SPI_SHIFT,   // SCLK toggling
      SPI_TRAIL    // SCLK parked low before deselect
   } spi_state_t;

endpackage

/* design/clock_ready_timer.sv */
// Clock ready hold-off
// Waits a fixed count after PLL lock, then releases the internal bus reset

`timescale 1ns/1ps
`include "sdr_board_defines.svh"

module clock_ready_timer (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic pll_locked,
   output logic bus_rst
);

   logic [`SDR_HOLDOFF_BITS-1:0] ready_count;   // Cycles since lock
   logic                         clocks_ready;
   logic [1:0]                   rst_sync;      // Reset synchronizer chain

   ////////////////////////////////////////
   // Hold-off counter
   ////////////////////////////////////////

   // Loss of lock clears everything at once, no clock needed
   always_ff @(posedge bus_clk or posedge reset_global or negedge pll_locked) begin
      if (reset_global || !pll_locked) begin
         ready_count  <= '0;
         clocks_ready <= 1'b0;
      end else if (!clocks_ready) begin
         ready_count  <= ready_count + 1'b1;
         clocks_ready <= &ready_count;   // Set on the all-ones edge
      end
   end

   ////////////////////////////////////////
   // Bus reset
   ////////////////////////////////////////

   // Two flops into bus_clk, reset held while clocks not ready
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], ~clocks_ready};
      end
   end

   assign bus_rst = rst_sync[1];

   // Ready never survives a dropped lock
   a_ready_needs_lock : assert property (
      @(posedge bus_clk) disable iff (reset_global)
      clocks_ready |-> pll_locked
   ) else $error("clocks_ready high without pll_locked");

endmodule

/* design/settings_regs.sv */
// APB settings slave for the board control registers
// Holds MISC and FE_GPIO, launches codec SPI frames, reports status

`timescale 1ns/1ps
`include "sdr_board_defines.svh"

module settings_regs (
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  sdr_board_pkg::apb_addr_t paddr,
   input  sdr_board_pkg::apb_data_t pwdata,
   output sdr_board_pkg::apb_data_t prdata,
   output logic                     pready,
   output logic                     pslverr,
   output sdr_board_pkg::misc_t     misc,
   output sdr_board_pkg::fe_gpio_t  fe_gpio,
   output logic                     spi_start,
   output sdr_board_pkg::spi_word_t spi_tx_word,
   input  logic                     spi_busy,
   input  sdr_board_pkg::spi_word_t spi_rx_word,
   input  logic                     ext_ref_locked_sync
);

   import sdr_board_pkg::*;

   logic access;     // APB access phase
   logic spi_wr;     // Write aimed at SPI_DATA
   logic stall;      // Hold pready low
   logic wr_done;    // Write completes this cycle
   logic addr_hit;   // Offset is one of the four registers

   ////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////

   assign access = psel && penable;
   assign spi_wr = pwrite && (paddr == `SDR_REG_SPI_DATA);

   // Back-pressure while a frame runs or is about to start
   assign stall = bus_rst || (spi_wr && (spi_busy || spi_start));

   assign pready  = access && !stall;
   assign wr_done = pready && pwrite;
   assign pslverr = pready && !addr_hit;   // Unmapped offset

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb begin
      addr_hit = 1'b1;
      prdata   = '0;
      case (paddr)
         `SDR_REG_MISC:     prdata = apb_data_t'(misc);
         `SDR_REG_FE_GPIO:  prdata = apb_data_t'(fe_gpio);
         `SDR_REG_SPI_DATA: prdata = apb_data_t'(spi_rx_word);   // Last codec reply
         `SDR_REG_STATUS:   prdata = apb_data_t'({spi_busy, ext_ref_locked_sync});
         default:           addr_hit = 1'b0;   // prdata stays zero
      endcase
   end

   ////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         misc      <= '0;
         fe_gpio   <= '0;
         spi_start <= 1'b0;
      end else begin
         spi_start <= wr_done && spi_wr;   // One-cycle launch pulse
         if (wr_done) begin
            case (paddr)
               `SDR_REG_MISC:    misc    <= pwdata[2:0];
               `SDR_REG_FE_GPIO: fe_gpio <= pwdata[7:0];
               default: ;   // STATUS read only
            endcase
         end
      end
   end

   // Frame word goes out with the start pulse
   always_ff @(posedge bus_clk) begin
      if (wr_done && spi_wr) begin
         spi_tx_word <= pwdata[`SDR_SPI_BITS-1:0];
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // pready only ends an access that had its setup cycle
   a_pready_in_access : assert property (
      @(posedge bus_clk) disable iff (bus_rst)
      pready |-> psel && penable && $past(psel)
   ) else $error("pready outside an APB access");

   // No launch into a busy SPI master
   a_start_when_idle : assert property (
      @(posedge bus_clk) disable iff (bus_rst)
      spi_start |-> !spi_busy
   ) else $error("spi_start while spi_busy");

endmodule

/* design/spi_shift_ctrl.sv */
// Codec SPI master
// Shifts 24-bit frames out MSB first and captures the transceiver reply

`timescale 1ns/1ps
`include "sdr_board_defines.svh"

module spi_shift_ctrl (
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  logic                     spi_start,
   input  sdr_board_pkg::spi_word_t spi_tx_word,
   output logic                     spi_busy,
   output sdr_board_pkg::spi_word_t spi_rx_word,
   output logic                     cat_spi_en,
   output logic                     cat_spi_clk,
   output logic                     cat_spi_di,
   input  logic                     cat_spi_do
);

   import sdr_board_pkg::*;

   localparam int DIV_W = $clog2(`SDR_SPI_HALF + 1);
   localparam int BIT_W = $clog2(`SDR_SPI_BITS);

   spi_state_t       state;
   logic [DIV_W-1:0] div_cnt;     // Cycles within a half period
   logic [BIT_W-1:0] bit_cnt;     // Bits sent so far
   logic             half_tick;   // Last cycle of a half period
   logic             last_bit;
   logic             cs_n;        // Internal enable, active low
   logic             sclk;        // Ungated serial clock
   spi_word_t        tx_shift;
   spi_word_t        rx_shift;

   assign half_tick = (div_cnt == DIV_W'(`SDR_SPI_HALF - 1));
   assign last_bit  = (bit_cnt == BIT_W'(`SDR_SPI_BITS - 1));

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state   <= SPI_IDLE;
         cs_n    <= 1'b1;
         sclk    <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         // Divider free-runs only inside a frame
         div_cnt <= (state == SPI_IDLE || half_tick) ? '0 : div_cnt + 1'b1;
         case (state)
            SPI_IDLE: begin
               if (spi_start) begin
                  cs_n    <= 1'b0;
                  bit_cnt <= '0;
                  state   <= SPI_LEAD;
               end
            end
            SPI_LEAD: begin
               if (half_tick) state <= SPI_SHIFT;   // MSB already on DI
            end
            SPI_SHIFT: begin
               if (half_tick) begin
                  sclk <= !sclk;
                  if (sclk) begin   // Falling edge ends a bit
                     bit_cnt <= bit_cnt + 1'b1;
                     if (last_bit) state <= SPI_TRAIL;
                  end
               end
            end
            SPI_TRAIL: begin
               if (half_tick) begin
                  cs_n  <= 1'b1;
                  state <= SPI_IDLE;
               end
            end
            default: state <= SPI_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Shift registers
   ////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (state == SPI_IDLE && spi_start) begin
         tx_shift <= spi_tx_word;
      end else if (state == SPI_SHIFT && half_tick && sclk) begin
         tx_shift <= {tx_shift[`SDR_SPI_BITS-2:0], 1'b0};   // Next bit while SCLK low
      end
      if (state == SPI_SHIFT && half_tick && !sclk) begin
         rx_shift <= {rx_shift[`SDR_SPI_BITS-2:0], cat_spi_do};   // Sample on rise
      end
      if (state == SPI_TRAIL && half_tick) begin
         spi_rx_word <= rx_shift;   // Stable once busy drops
      end
   end

   ////////////////////////////////////////
   // Pins
   ////////////////////////////////////////

   assign spi_busy    = (state != SPI_IDLE);
   assign cat_spi_en  = cs_n;
   assign cat_spi_clk = ~cs_n & sclk;                     // Gated off when deselected
   assign cat_spi_di  = ~cs_n & tx_shift[`SDR_SPI_BITS-1];

   // Clock parked low whenever the codec is deselected
   a_sclk_parked : assert property (
      @(posedge bus_clk) disable iff (bus_rst)
      cat_spi_en |-> !cat_spi_clk && !sclk
   ) else $error("SCLK not idle while cat_spi_en high");

endmodule

/* design/frontend_ctrl.sv */
// RF front end, LED and reference select outputs
// Registers the switch mapping and syncs the external reference lock

`timescale 1ns/1ps

module frontend_ctrl (
   input  logic                    bus_clk,
   input  logic                    bus_rst,
   input  sdr_board_pkg::fe_gpio_t fe_gpio,
   input  sdr_board_pkg::misc_t    misc,
   input  logic                    pps_in,
   input  logic                    clkin_10mhz,
   input  logic                    ext_ref_locked,
   output logic                    ext_ref_locked_sync,
   output logic                    clkin_10mhz_req,
   output logic                    fe_tx_pa_en,
   output logic                    fe_sel_rx_rx2,
   output logic                    fe_sel_trx_tx,
   output logic                    fe_sel_rx_trx,
   output logic                    fe_sel_trx_rx,
   output logic                    led_trx_r,
   output logic                    led_trx_g,
   output logic                    led_rx2_g,
   output logic                    led_s0,
   output logic                    led_s1,
   output logic                    cat_resetn
);

   logic lock_meta;   // First synchronizer stage
   logic ext_ref;     // Selected reference

   // PPS wins over 10 MHz, neither gives zero
   assign ext_ref = misc[2] ? pps_in : (misc[0] ? clkin_10mhz : 1'b0);

   assign led_s1 = ~ext_ref;               // LEDs are active low
   assign led_s0 = ~ext_ref_locked_sync;

   ////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         {fe_tx_pa_en, fe_sel_rx_rx2, fe_sel_trx_tx, fe_sel_rx_trx, fe_sel_trx_rx} <= '0;
         {led_trx_r, led_trx_g, led_rx2_g} <= 3'b111;   // LEDs off
         cat_resetn          <= 1'b0;   // Codec held in reset
         clkin_10mhz_req     <= 1'b0;
         lock_meta           <= 1'b0;
         ext_ref_locked_sync <= 1'b0;
      end else begin
         {fe_tx_pa_en, fe_sel_rx_rx2, fe_sel_trx_tx, fe_sel_rx_trx, fe_sel_trx_rx} <= fe_gpio[7:3];
         led_trx_r           <= ~fe_gpio[0];
         led_trx_g           <= ~fe_gpio[1];
         led_rx2_g           <= ~fe_gpio[2];
         cat_resetn          <= misc[1];    // codec_run
         clkin_10mhz_req     <= misc[0];    // ref_sel
         lock_meta           <= ext_ref_locked;
         ext_ref_locked_sync <= lock_meta;
      end
   end

endmodule

/* design/sdr_board.sv */
// SDR board control top level
// Clock hold-off, APB settings, codec SPI master and RF front end

`timescale 1ns/1ps

module sdr_board (
   input  logic                     bus_clk,
   input  logic                     reset_global,
   input  logic                     pll_locked,
   // APB settings bus
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  sdr_board_pkg::apb_addr_t paddr,
   input  sdr_board_pkg::apb_data_t pwdata,
   output sdr_board_pkg::apb_data_t prdata,
   output logic                     pready,
   output logic                     pslverr,
   // Codec SPI
   output logic                     cat_spi_en,
   output logic                     cat_spi_clk,
   output logic                     cat_spi_di,
   input  logic                     cat_spi_do,
   output logic                     cat_resetn,
   // Reference inputs
   input  logic                     pps_in,
   input  logic                     clkin_10mhz,
   input  logic                     ext_ref_locked,
   output logic                     clkin_10mhz_req,
   // RF switches and LEDs
   output logic                     fe_tx_pa_en,
   output logic                     fe_sel_rx_rx2,
   output logic                     fe_sel_trx_tx,
   output logic                     fe_sel_rx_trx,
   output logic                     fe_sel_trx_rx,
   output logic                     led_trx_r,
   output logic                     led_trx_g,
   output logic                     led_rx2_g,
   output logic                     led_s0,
   output logic                     led_s1
);

   import sdr_board_pkg::*;

   logic      bus_rst;
   misc_t     misc;
   fe_gpio_t  fe_gpio;
   logic      spi_start;
   spi_word_t spi_tx_word;
   logic      spi_busy;
   spi_word_t spi_rx_word;
   logic      ext_ref_locked_sync;

   ////////////////////////////////////////
   // Reset and settings
   ////////////////////////////////////////

   clock_ready_timer u_timer (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .pll_locked   (pll_locked),
      .bus_rst      (bus_rst)
   );

   settings_regs u_regs (
      .bus_clk (bus_clk), .bus_rst (bus_rst),
      .psel (psel), .penable (penable), .pwrite (pwrite),
      .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
      .pready (pready), .pslverr (pslverr),
      .misc (misc), .fe_gpio (fe_gpio),
      .spi_start (spi_start), .spi_tx_word (spi_tx_word),
      .spi_busy (spi_busy), .spi_rx_word (spi_rx_word),
      .ext_ref_locked_sync (ext_ref_locked_sync)
   );

   ////////////////////////////////////////
   // Codec and front end
   ////////////////////////////////////////

   spi_shift_ctrl u_spi (
      .bus_clk (bus_clk), .bus_rst (bus_rst),
      .spi_start (spi_start), .spi_tx_word (spi_tx_word),
      .spi_busy (spi_busy), .spi_rx_word (spi_rx_word),
      .cat_spi_en (cat_spi_en), .cat_spi_clk (cat_spi_clk),
      .cat_spi_di (cat_spi_di), .cat_spi_do (cat_spi_do)
   );

   frontend_ctrl u_fe (
      .bus_clk (bus_clk), .bus_rst (bus_rst),
      .fe_gpio (fe_gpio), .misc (misc),
      .pps_in (pps_in), .clkin_10mhz (clkin_10mhz),
      .ext_ref_locked (ext_ref_locked), .ext_ref_locked_sync (ext_ref_locked_sync),
      .clkin_10mhz_req (clkin_10mhz_req),
      .fe_tx_pa_en (fe_tx_pa_en), .fe_sel_rx_rx2 (fe_sel_rx_rx2),
      .fe_sel_trx_tx (fe_sel_trx_tx), .fe_sel_rx_trx (fe_sel_rx_trx),
      .fe_sel_trx_rx (fe_sel_trx_rx),
      .led_trx_r (led_trx_r), .led_trx_g (led_trx_g), .led_rx2_g (led_rx2_g),
      .led_s0 (led_s0), .led_s1 (led_s1),
      .cat_resetn (cat_resetn)
   );

endmodule

/* bench/tb_sdr_board.sv */
// Testbench for the SDR board control slice
// APB traffic, codec SPI model and checks on the board outputs

`timescale 1ns/1ps
`include "sdr_board_defines.svh"

module tb_sdr_board;

   import sdr_board_pkg::*;

   // Frame is all bits plus one lead and one trail half period
   localparam int FRAME_CYCLES = 2 * `SDR_SPI_HALF * (`SDR_SPI_BITS + 1);
   localparam int MAX_CYCLES   = 4 * ((1 << `SDR_HOLDOFF_BITS) + 6 * FRAME_CYCLES);

   logic      bus_clk, reset_global, pll_locked;
   logic      psel, penable, pwrite, pready, pslverr;
   apb_addr_t paddr;
   apb_data_t pwdata, prdata;
   logic      cat_spi_en, cat_spi_clk, cat_spi_di, cat_spi_do, cat_resetn;
   logic      pps_in, clkin_10mhz, ext_ref_locked, clkin_10mhz_req;
   logic      fe_tx_pa_en, fe_sel_rx_rx2, fe_sel_trx_tx, fe_sel_rx_trx, fe_sel_trx_rx;
   logic      led_trx_r, led_trx_g, led_rx2_g, led_s0, led_s1;

   apb_data_t   rd_data;       // Last APB read
   logic        rd_err;
   int          wait_cycles;   // Access cycles with pready low
   int          cycle_count;
   int          frames_done;   // Frames seen by the codec model
   spi_word_t   sent_words[$]; // Codec reply patterns
   spi_word_t   got_words[$];  // Words captured from cat_spi_di
   logic [31:0] stim_rng;

   sdr_board u_sdr_board (.*);

   ////////////////////////////////////////
   // Clock, run limit, helpers
   ////////////////////////////////////////

   initial begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;   // 20 ns
   end

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge bus_clk);
         cycle_count++;
         if (cycle_count >= MAX_CYCLES) report_fail("run timed out before all tests finished");
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else report_fail($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // APB transfer as a setup cycle then access cycles until pready
   task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata);
      @(negedge bus_clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge bus_clk);
      penable     = 1'b1;
      wait_cycles = 0;
      #5;   // Mid low phase away from both edges
      while (!pready) begin
         wait_cycles++;
         @(negedge bus_clk);
         #5;
      end
      rd_data = prdata;
      rd_err  = pslverr;
      @(negedge bus_clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Open read that must stay stalled with the codec in reset
   task automatic check_bus_held(input int cycles);
      @(negedge bus_clk);
      psel   = 1'b1;
      pwrite = 1'b0;
      paddr  = `SDR_REG_STATUS;
      @(negedge bus_clk);
      penable = 1'b1;
      repeat (cycles) begin
         #5;
         check_value("pready", pready, 1'b0);
         check_value("cat_resetn", cat_resetn, 1'b0);
         @(negedge bus_clk);
      end
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Sets both reference sources and checks the selected one on led_s1
   task automatic check_ref_led(input logic pps, input logic clk10, input logic exp_led);
      @(negedge bus_clk);
      pps_in      = pps;
      clkin_10mhz = clk10;
      #5;
      check_value("led_s1", led_s1, exp_led);
   endtask

   ////////////////////////////////////////
   // Codec model and pin checks
   ////////////////////////////////////////

   // DO changes after SCLK falls and DI is captured on rises
   initial begin
      logic [31:0] codec_rng;
      spi_word_t   tx_pat, rx_pat;
      logic        prev_en, prev_clk;
      int          low_cycles, rx_bits;
      codec_rng   = 32'd62461 ^ 32'hFFFF_FFFF;   // Own stream apart from the stimulus
      cat_spi_do  = 1'b0;
      prev_en     = 1'b1;
      prev_clk    = 1'b0;
      frames_done = 0;
      forever begin
         @(negedge bus_clk);
         if (prev_en && !cat_spi_en) begin   // Frame start
            codec_rng  = lcg_next(codec_rng);
            tx_pat     = codec_rng[31:8];
            sent_words.push_back(tx_pat);
            cat_spi_do = tx_pat[`SDR_SPI_BITS-1];
            low_cycles = 1;
            rx_bits    = 0;
         end else if (!cat_spi_en) begin
            low_cycles++;
            if (!prev_clk && cat_spi_clk) begin
               rx_pat = {rx_pat[`SDR_SPI_BITS-2:0], cat_spi_di};   // SCLK rise
               rx_bits++;
            end else if (prev_clk && !cat_spi_clk) begin
               tx_pat     = {tx_pat[`SDR_SPI_BITS-2:0], 1'b0};    // SCLK fall
               cat_spi_do = tx_pat[`SDR_SPI_BITS-1];
            end
         end else if (!prev_en) begin   // Frame end
            check_value("frame_cycles", low_cycles, FRAME_CYCLES);
            check_value("frame_bits", rx_bits, `SDR_SPI_BITS);
            got_words.push_back(rx_pat);
            frames_done++;
         end
         prev_en  = cat_spi_en;
         prev_clk = cat_spi_clk;
      end
   end

   a_sclk_idle : assert property (@(posedge bus_clk) disable iff (reset_global)
      cat_spi_en |-> !cat_spi_clk && !cat_spi_di)
      else report_fail("SCLK or DI active while cat_spi_en is high");

   a_ready_in_access : assert property (@(posedge bus_clk) disable iff (reset_global)
      pready |-> psel && penable)
      else report_fail("pready high outside an APB access");

   a_err_data : assert property (@(posedge bus_clk) disable iff (reset_global)
      pslverr |-> prdata == '0)
      else report_fail("prdata not zero on an APB error");

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      apb_data_t w1, w2, w3;
      fe_gpio_t  fe;
      int        frames_before;
      reset_global   = 1'b1;
      pll_locked     = 1'b0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      pps_in         = 1'b0;
      clkin_10mhz    = 1'b0;
      ext_ref_locked = 1'b0;
      stim_rng       = 32'd62461;
      repeat (2) @(negedge bus_clk);
      reset_global = 1'b0;

      // Bring-up with the bus stalled through the hold-off
      @(negedge bus_clk);
      pll_locked = 1'b1;
      check_bus_held(1 << `SDR_HOLDOFF_BITS);
      apb_access(1'b0, `SDR_REG_STATUS, '0);
      check_value("status", rd_data, 32'h0);

      // Front end mapping one cycle after the write
      stim_rng = lcg_next(stim_rng);
      fe       = stim_rng[23:16];
      apb_access(1'b1, `SDR_REG_FE_GPIO, apb_data_t'(fe));
      @(negedge bus_clk);
      #5;
      check_value("fe_switches", {fe_tx_pa_en, fe_sel_rx_rx2, fe_sel_trx_tx,
                                  fe_sel_rx_trx, fe_sel_trx_rx}, fe[7:3]);
      check_value("fe_leds", {led_rx2_g, led_trx_g, led_trx_r}, {~fe[2], ~fe[1], ~fe[0]});
      apb_access(1'b0, `SDR_REG_FE_GPIO, '0);
      check_value("fe_gpio", rd_data, apb_data_t'(fe));
      check_value("cat_resetn", cat_resetn, 1'b0);
      apb_access(1'b1, `SDR_REG_MISC, 32'h2);   // codec_run
      @(negedge bus_clk);
      #5;
      check_value("cat_resetn", cat_resetn, 1'b1);

      // Single SPI frame
      stim_rng = lcg_next(stim_rng);
      w1       = apb_data_t'(stim_rng[31:8]);
      apb_access(1'b1, `SDR_REG_SPI_DATA, w1);
      wait (frames_done == 1);
      check_value("cat_spi_di", got_words[0], w1);
      apb_access(1'b0, `SDR_REG_SPI_DATA, '0);
      check_value("spi_data", rd_data, apb_data_t'(sent_words[0]));

      // Second write while busy is held off
      stim_rng = lcg_next(stim_rng);
      w2       = apb_data_t'(stim_rng[31:8]);
      stim_rng = lcg_next(stim_rng);
      w3       = apb_data_t'(stim_rng[31:8]);
      apb_access(1'b1, `SDR_REG_SPI_DATA, w2);
      apb_access(1'b0, `SDR_REG_STATUS, '0);
      check_value("status_busy", rd_data[1], 1'b1);
      frames_before = frames_done;
      apb_access(1'b1, `SDR_REG_SPI_DATA, w3);
      assert (wait_cycles > 0) else report_fail("SPI_DATA write was not held while busy");
      check_value("frames_done", frames_done, frames_before + 1);
      wait (frames_done == frames_before + 2);
      check_value("cat_spi_di", got_words[1], w2);
      check_value("cat_spi_di", got_words[2], w3);
      apb_access(1'b0, `SDR_REG_SPI_DATA, '0);
      check_value("spi_data", rd_data, apb_data_t'(sent_words[2]));

      // Reference select
      apb_access(1'b1, `SDR_REG_MISC, 32'h3);   // 10 MHz input
      check_ref_led(1'b0, 1'b1, 1'b0);
      check_ref_led(1'b1, 1'b0, 1'b1);
      check_value("clkin_10mhz_req", clkin_10mhz_req, 1'b1);
      apb_access(1'b1, `SDR_REG_MISC, 32'h7);   // PPS wins
      check_ref_led(1'b1, 1'b0, 1'b0);
      check_ref_led(1'b0, 1'b1, 1'b1);
      apb_access(1'b1, `SDR_REG_MISC, 32'h2);   // No source
      check_ref_led(1'b1, 1'b1, 1'b1);
      check_value("clkin_10mhz_req", clkin_10mhz_req, 1'b0);
      @(negedge bus_clk);
      ext_ref_locked = 1'b1;
      repeat (3) @(negedge bus_clk);
      check_value("led_s0", led_s0, 1'b0);
      apb_access(1'b0, `SDR_REG_STATUS, '0);
      check_value("status", rd_data, 32'h1);

      // Unmapped offsets
      apb_access(1'b0, 8'h10, '0);
      check_value("pslverr", rd_err, 1'b1);
      check_value("prdata", rd_data, 32'h0);
      apb_access(1'b1, 8'h3C, 32'hFFFF_FFFF);
      check_value("pslverr", rd_err, 1'b1);

      // Loss of lock back to the reset state
      apb_access(1'b1, `SDR_REG_FE_GPIO, 32'hFF);
      apb_access(1'b1, `SDR_REG_MISC, 32'h3);
      @(negedge bus_clk);
      pll_locked = 1'b0;
      repeat (4) @(negedge bus_clk);
      check_value("fe_switches", {fe_tx_pa_en, fe_sel_rx_rx2, fe_sel_trx_tx,
                                  fe_sel_rx_trx, fe_sel_trx_rx}, 5'h00);
      check_value("fe_leds", {led_rx2_g, led_trx_g, led_trx_r}, 3'h7);
      check_value("clkin_10mhz_req", clkin_10mhz_req, 1'b0);
      check_value("led_s0", led_s0, 1'b1);   // Lock sync cleared
      check_value("led_s1", led_s1, 1'b1);   // No source selected
      check_value("cat_spi_en", cat_spi_en, 1'b1);
      check_bus_held(8);
      $display("sim passed");
      $finish;
   end

endmodule

/* tb.f */
+incdir+design
design/sdr_board_pkg.sv
design/clock_ready_timer.sv
design/settings_regs.sv
design/spi_shift_ctrl.sv
design/frontend_ctrl.sv
design/sdr_board.sv
bench/tb_sdr_board.sv

/* run_sim.sh */
#!/bin/sh
# Build the SDR board testbench with Verilator and run it
# Exit status is nonzero unless the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sdr_board -f tb.f \
   && ./obj_dir/Vtb_sdr_board | tee /dev/stderr | grep -q "sim passed" \
   && echo "run_sim: PASS" \
   || { echo "run_sim: FAIL"; exit 1; }
